// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= huff_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: src/huff_apb_decode.sv
`timescale 1ns/1ns
`include "huff_params.svh"

module huff_apb_decode import huff_pkg::*; (
  input  logic                    hwclk_i,
  input  logic                    rst_n_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`HUFF_ADDR_W-1:0] paddr_i,
  input  logic [`HUFF_DATA_W-1:0] pwdata_i,
  huff_cmd_if.dec                 cmd,
  input  logic                    scan_busy_i,
  output logic                    scan_start_o,
  output rd_sel_e                 rd_sel_o,
  output logic                    pready_o,
  output logic                    pslverr_o
);

  typedef enum logic {
    ST_IDLE,
    ST_CNT_WAIT
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   access;
  logic   hit_char;
  logic   hit_ctrl;
  logic   hit_status;
  logic   hit_least;
  logic   hit_lcnt;
  logic   hit_cnt;
  logic   err;
  logic   busy;
  logic   wr_done;

  assign access = psel_i & penable_i;
  assign busy   = cmd.busy | scan_busy_i;

  // offset decode
  assign hit_char   = (paddr_i == OFF_CHAR);
  assign hit_ctrl   = (paddr_i == OFF_CTRL);
  assign hit_status = (paddr_i == OFF_STATUS);
  assign hit_least  = (paddr_i == OFF_LEAST);
  assign hit_lcnt   = (paddr_i == OFF_LEAST_CNT);
  assign hit_cnt    = (paddr_i >= OFF_COUNT) && (paddr_i[1:0] == 2'b00);

  // wrong direction or unmapped
  assign err = pwrite_i ? ~(hit_char | hit_ctrl)
                        : ~(hit_status | hit_least | hit_lcnt | hit_cnt);

  always_comb begin
    state_d   = ST_IDLE;
    pready_o  = 1'b0;
    pslverr_o = 1'b0;
    cmd.rd_v  = 1'b0;
    if (access) begin
      if (err) begin
        pready_o  = 1'b1;
        pslverr_o = 1'b1;
      end else if (pwrite_i) begin
        // hold writes until table and scanner are idle
        pready_o = ~busy;
      end else if (hit_cnt) begin
        if (state_q == ST_CNT_WAIT) begin
          pready_o = 1'b1;
        end else begin
          cmd.rd_v = 1'b1;
          state_d  = ST_CNT_WAIT;
        end
      end else begin
        pready_o = 1'b1;
      end
    end
  end

  always_ff @(posedge hwclk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // commands fire on the completing cycle only
  assign wr_done = access & pready_o & pwrite_i & ~err;

  assign cmd.inc_v   = wr_done & hit_char;
  assign cmd.inc_sym = pwdata_i[$bits(sym_t)-1:0];
  assign cmd.clr_v   = wr_done & hit_ctrl & pwdata_i[0];
  assign cmd.rd_sym  = paddr_i[$bits(sym_t)+1:2];

  // a clear also restarts the scanner so stale results drop
  assign scan_start_o = wr_done & hit_ctrl & (pwdata_i[0] | pwdata_i[1]);

  always_comb begin
    rd_sel_o = RD_NONE;
    if (access && !pwrite_i && !err) begin
      if (hit_status) begin
        rd_sel_o = RD_STATUS;
      end else if (hit_least) begin
        rd_sel_o = RD_LEAST;
      end else if (hit_lcnt) begin
        rd_sel_o = RD_LEAST_CNT;
      end else if (hit_cnt) begin
        rd_sel_o = RD_COUNT;
      end
    end
  end

endmodule

// File: src/huff_cmd_if.sv
`timescale 1ns/1ns

interface huff_cmd_if import huff_pkg::*; ();

  // single cycle increment
  logic inc_v;
  sym_t inc_sym;

  // starts a full table clear
  logic clr_v;

  // count read, data follows one cycle later
  logic rd_v;
  sym_t rd_sym;
  cnt_t rd_cnt;

  // high while the clear walks the table
  logic busy;

  modport dec (
    output inc_v, inc_sym, clr_v, rd_v, rd_sym,
    input  rd_cnt, busy
  );

  modport tbl (
    input  inc_v, inc_sym, clr_v, rd_v, rd_sym,
    output rd_cnt, busy
  );

endinterface

// File: src/huff_hist_table.sv
`timescale 1ns/1ns
`include "huff_params.svh"

module huff_hist_table import huff_pkg::*; (
  input  logic    hwclk_i,
  input  logic    rst_n_i,
  huff_cmd_if.tbl cmd,
  input  sym_t    scan_sym_i,
  output cnt_t    scan_cnt_o
);

  cnt_t counts [`HUFF_ALPHA];
  sym_t clr_idx;
  logic clr_busy;
  cnt_t rd_cnt_q;
  logic inc_sat;

  // entry already at the top value
  assign inc_sat = (counts[cmd.inc_sym] == '1);

  always_ff @(posedge hwclk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `HUFF_ALPHA; i++) begin
        counts[i] <= '0;
      end
    end else if (clr_busy) begin
      counts[clr_idx] <= '0;
    end else if (cmd.inc_v && !inc_sat) begin
      counts[cmd.inc_sym] <= counts[cmd.inc_sym] + 1'b1;
    end
  end

  // clear walks one entry per cycle
  always_ff @(posedge hwclk_i) begin
    if (!rst_n_i) begin
      clr_busy <= 1'b0;
      clr_idx  <= '0;
    end else if (cmd.clr_v) begin
      clr_busy <= 1'b1;
      clr_idx  <= '0;
    end else if (clr_busy) begin
      clr_idx <= clr_idx + 1'b1;
      if (clr_idx == sym_t'(`HUFF_ALPHA - 1)) begin
        clr_busy <= 1'b0;
      end
    end
  end

  // registered read port for apb
  always_ff @(posedge hwclk_i) begin
    if (cmd.rd_v) begin
      rd_cnt_q <= counts[cmd.rd_sym];
    end
  end

  assign cmd.rd_cnt = rd_cnt_q;
  assign cmd.busy   = clr_busy;

  // every entry is headed for zero once a clear runs,
  // so a scan alongside it sees an empty table
  assign scan_cnt_o = clr_busy ? '0 : counts[scan_sym_i];

endmodule

// File: src/huff_least_scan.sv
`timescale 1ns/1ns
`include "huff_params.svh"

module huff_least_scan import huff_pkg::*; (
  input  logic   hwclk_i,
  input  logic   rst_n_i,
  input  logic   scan_start_i,
  input  cnt_t   scan_cnt_i,
  output sym_t   scan_sym_o,
  output least_t least_o,
  output logic   scan_busy_o,
  output logic   scan_done_o
);

  typedef enum logic [1:0] {
    SC_IDLE,
    SC_WALK,
    SC_FINISH
  } scan_state_e;

  scan_state_e state_q;
  sym_t        idx_q;
  least_t      least_q;
  logic        done_q;
  logic        take1;
  logic        take2;

  // indices ascend, so a tie keeps the entry already held
  assign take1 = !least_q.vld1 || (scan_cnt_i < least_q.cnt1);
  assign take2 = !least_q.vld2 || (scan_cnt_i < least_q.cnt2);

  always_ff @(posedge hwclk_i) begin
    if (!rst_n_i) begin
      state_q <= SC_IDLE;
      idx_q   <= '0;
      least_q <= '0;
      done_q  <= 1'b0;
    end else if (scan_start_i) begin
      state_q      <= SC_WALK;
      idx_q        <= '0;
      least_q.vld1 <= 1'b0;
      least_q.vld2 <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      case (state_q)
        SC_WALK: begin
          // zero counts never qualify
          if (scan_cnt_i != '0) begin
            if (take1) begin
              least_q.sym2 <= least_q.sym1;
              least_q.cnt2 <= least_q.cnt1;
              least_q.vld2 <= least_q.vld1;
              least_q.sym1 <= idx_q;
              least_q.cnt1 <= scan_cnt_i;
              least_q.vld1 <= 1'b1;
            end else if (take2) begin
              least_q.sym2 <= idx_q;
              least_q.cnt2 <= scan_cnt_i;
              least_q.vld2 <= 1'b1;
            end
          end
          idx_q <= idx_q + 1'b1;
          if (idx_q == sym_t'(`HUFF_ALPHA - 1)) begin
            state_q <= SC_FINISH;
          end
        end
        SC_FINISH: begin
          state_q <= SC_IDLE;
          done_q  <= 1'b1;
        end
        default: begin
          state_q <= SC_IDLE;
        end
      endcase
    end
  end

  assign scan_sym_o  = idx_q;
  assign least_o     = least_q;
  assign scan_busy_o = (state_q != SC_IDLE);
  assign scan_done_o = done_q;

endmodule

// File: src/huff_params.svh
`ifndef HUFF_PARAMS_SVH
`define HUFF_PARAMS_SVH

// alphabet of 7-bit characters
`define HUFF_ALPHA 128

// per-character count, saturates at all ones
`define HUFF_CNT_W 16

// apb bus widths
`define HUFF_ADDR_W 10
`define HUFF_DATA_W 32

`endif

// File: src/huff_pkg.sv
`include "huff_params.svh"

package huff_pkg;

  // one character of the input stream
  typedef logic [$clog2(`HUFF_ALPHA)-1:0] sym_t;

  // one frequency table entry
  typedef logic [`HUFF_CNT_W-1:0] cnt_t;

  // full apb data word
  typedef logic [`HUFF_DATA_W-1:0] apb_data_t;

  // register map, count window starts at OFF_COUNT
  typedef enum logic [`HUFF_ADDR_W-1:0] {
    OFF_CHAR      = 10'h000,
    OFF_CTRL      = 10'h004,
    OFF_STATUS    = 10'h008,
    OFF_LEAST     = 10'h00C,
    OFF_LEAST_CNT = 10'h010,
    OFF_COUNT     = 10'h200
  } reg_off_e;

  // read data source
  typedef enum logic [2:0] {
    RD_NONE,
    RD_STATUS,
    RD_LEAST,
    RD_LEAST_CNT,
    RD_COUNT
  } rd_sel_e;

  // two least frequent characters, slot 1 is the smaller
  typedef struct packed {
    sym_t sym1;
    sym_t sym2;
    cnt_t cnt1;
    cnt_t cnt2;
    logic vld1;
    logic vld2;
  } least_t;

endpackage

// File: src/huff_result.sv
`timescale 1ns/1ns
`include "huff_params.svh"

module huff_result import huff_pkg::*; (
  input  logic                    hwclk_i,
  input  logic                    rst_n_i,
  input  rd_sel_e                 rd_sel_i,
  input  least_t                  least_i,
  input  cnt_t                    rd_cnt_i,
  input  logic                    tbl_busy_i,
  input  logic                    scan_busy_i,
  input  logic                    scan_done_i,
  output logic [`HUFF_DATA_W-1:0] prdata_o
);

  typedef logic [`HUFF_DATA_W/2-1:0] half_t;

  least_t    least_q;
  apb_data_t status_word;
  apb_data_t least_word;
  apb_data_t lcnt_word;

  // results stay stable for the host between scans
  always_ff @(posedge hwclk_i) begin
    if (!rst_n_i) begin
      least_q <= '0;
    end else if (scan_done_i) begin
      least_q <= least_i;
    end else if (scan_busy_i) begin
      least_q.vld1 <= 1'b0;
      least_q.vld2 <= 1'b0;
    end
  end

  // bit0 busy, bit1 scan done
  assign status_word = apb_data_t'({scan_done_i, tbl_busy_i | scan_busy_i});

  assign least_word = apb_data_t'({least_q.vld2, least_q.sym2,
                                   least_q.vld1, least_q.sym1});

  // least2 count in the upper half
  assign lcnt_word = {half_t'(least_q.cnt2), half_t'(least_q.cnt1)};

  always_comb begin
    case (rd_sel_i)
      RD_STATUS:    prdata_o = status_word;
      RD_LEAST:     prdata_o = least_word;
      RD_LEAST_CNT: prdata_o = lcnt_word;
      RD_COUNT:     prdata_o = apb_data_t'(rd_cnt_i);
      default:      prdata_o = '0;
    endcase
  end

endmodule

// File: src/huff_top.sv
`timescale 1ns/1ns
`include "huff_params.svh"

module huff_top import huff_pkg::*; (
  input  logic                    hwclk_i,
  input  logic                    rst_n_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`HUFF_ADDR_W-1:0] paddr_i,
  input  logic [`HUFF_DATA_W-1:0] pwdata_i,
  output logic [`HUFF_DATA_W-1:0] prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o
);

  logic    scan_start;
  logic    scan_busy;
  logic    scan_done;
  sym_t    scan_sym;
  cnt_t    scan_cnt;
  least_t  least;
  rd_sel_e rd_sel;

  huff_cmd_if cmd_bus ();

  huff_apb_decode i_decode (
    .hwclk_i      (hwclk_i),
    .rst_n_i      (rst_n_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .cmd          (cmd_bus.dec),
    .scan_busy_i  (scan_busy),
    .scan_start_o (scan_start),
    .rd_sel_o     (rd_sel),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o)
  );

  huff_hist_table i_table (
    .hwclk_i    (hwclk_i),
    .rst_n_i    (rst_n_i),
    .cmd        (cmd_bus.tbl),
    .scan_sym_i (scan_sym),
    .scan_cnt_o (scan_cnt)
  );

  huff_least_scan i_scan (
    .hwclk_i      (hwclk_i),
    .rst_n_i      (rst_n_i),
    .scan_start_i (scan_start),
    .scan_cnt_i   (scan_cnt),
    .scan_sym_o   (scan_sym),
    .least_o      (least),
    .scan_busy_o  (scan_busy),
    .scan_done_o  (scan_done)
  );

  huff_result i_result (
    .hwclk_i     (hwclk_i),
    .rst_n_i     (rst_n_i),
    .rd_sel_i    (rd_sel),
    .least_i     (least),
    .rd_cnt_i    (cmd_bus.rd_cnt),
    .tbl_busy_i  (cmd_bus.busy),
    .scan_busy_i (scan_busy),
    .scan_done_i (scan_done),
    .prdata_o    (prdata_o)
  );

endmodule

// File: verif/huff_tb.sv
`timescale 1ns/1ns
`include "huff_params.svh"

module huff_tb import huff_pkg::*; ();

  typedef logic [`HUFF_ADDR_W-1:0] addr_t;

  logic        hwclk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  addr_t       paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] lfsr_q;
  cnt_t        model [`HUFF_ALPHA];
  int          errors;
  int          failed_tests;
  int          test_start;
  int          waits;
  logic        bus_hung;
  apb_data_t   rdata;
  logic        slverr;

  huff_top i_dut (
    .hwclk_i   (hwclk),
    .rst_n_i   (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
  );

  initial begin
    hwclk = 1'b0;
    forever #5 hwclk = ~hwclk;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // one transfer that leaves its results in rdata, slverr and waits
  task automatic apb_xfer(input logic wr, input addr_t addr, input apb_data_t wdata);
    int limit;
    limit = 4 * `HUFF_ALPHA;
    waits = 0;
    if (!bus_hung) begin
      @(posedge hwclk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge hwclk);
      penable <= 1'b1;
      @(negedge hwclk);
      while (!pready && waits < limit) begin
        waits++;
        @(negedge hwclk);
      end
      rdata  = prdata;
      slverr = pslverr;
      if (!pready) begin
        $display("timeout: no pready within %0d cycles at offset 0x%03h", limit, addr);
        errors++;
        bus_hung = 1'b1;
      end
      @(posedge hwclk);
      psel    <= 1'b0;
      penable <= 1'b0;
    end
  endtask

  task automatic put_char(input sym_t c);
    apb_xfer(1'b1, OFF_CHAR, apb_data_t'(c));
    if (model[c] != '1) begin
      model[c] = model[c] + cnt_t'(1);
    end
  endtask

  task automatic clear_table();
    apb_xfer(1'b1, OFF_CTRL, 32'h1);
    foreach (model[i]) model[i] = '0;
  endtask

  task automatic compare_cnt(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%04h, expected 0x%04h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_word(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // symbol and count only matter in a valid slot
  task automatic compare_least(input least_t got, input least_t exp);
    if (got.vld1 !== exp.vld1 || got.vld2 !== exp.vld2 ||
        (exp.vld1 && (got.sym1 !== exp.sym1 || got.cnt1 !== exp.cnt1)) ||
        (exp.vld2 && (got.sym2 !== exp.sym2 || got.cnt2 !== exp.cnt2))) begin
      $display("Mismatch least: got 0x%012h, expected 0x%012h", got, exp);
      errors++;
    end
  endtask

  function automatic least_t model_least();
    least_t l;
    l = '0;
    // smallest nonzero count with ties to the lower index
    for (int i = 0; i < `HUFF_ALPHA; i++) begin
      if (model[i] != '0 && (!l.vld1 || model[i] < l.cnt1)) begin
        l.sym1 = sym_t'(i);
        l.cnt1 = model[i];
        l.vld1 = 1'b1;
      end
    end
    // same again without the first pick
    for (int i = 0; i < `HUFF_ALPHA; i++) begin
      if (model[i] != '0 && !(l.vld1 && sym_t'(i) == l.sym1) &&
          (!l.vld2 || model[i] < l.cnt2)) begin
        l.sym2 = sym_t'(i);
        l.cnt2 = model[i];
        l.vld2 = 1'b1;
      end
    end
    return l;
  endfunction

  task automatic read_least(output least_t got);
    apb_xfer(1'b0, OFF_LEAST, '0);
    got.sym1 = rdata[6:0];
    got.vld1 = rdata[7];
    got.sym2 = rdata[14:8];
    got.vld2 = rdata[15];
    apb_xfer(1'b0, OFF_LEAST_CNT, '0);
    got.cnt1 = rdata[15:0];
    got.cnt2 = rdata[31:16];
  endtask

  task automatic run_scan();
    int polls;
    polls = 0;
    apb_xfer(1'b1, OFF_CTRL, 32'h2);
    rdata = '0;
    while (!rdata[1] && polls < 4 * `HUFF_ALPHA && !bus_hung) begin
      apb_xfer(1'b0, OFF_STATUS, '0);
      polls++;
    end
    if (!rdata[1]) begin
      $display("timeout: scan done never set after %0d status polls", polls);
      errors++;
    end else begin
      compare_word("status", rdata, 32'h2);
    end
  endtask

  task automatic check_counts();
    for (int i = 0; i < `HUFF_ALPHA; i++) begin
      apb_xfer(1'b0, addr_t'(OFF_COUNT + 4 * i), '0);
      compare_cnt($sformatf("count[%0d]", i), cnt_t'(rdata), model[i]);
      compare_flag("pslverr_o", slverr, 1'b0);
      if (waits != 1) begin
        $display("count read of symbol %0d took %0d wait states instead of one", i, waits);
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name);
    if (errors == test_start) begin
      $display("test %-20s ok", name);
    end else begin
      $display("test %-20s %0d errors", name, errors - test_start);
      failed_tests++;
    end
  endtask

  initial begin
    least_t got;
    sym_t   c;
    lfsr_q       = 32'h5e30d351;
    errors       = 0;
    failed_tests = 0;
    bus_hung     = 1'b0;
    rst_n   <= 1'b0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= '0;
    pwdata  <= '0;
    foreach (model[i]) model[i] = '0;
    repeat (3) @(posedge hwclk);
    rst_n <= 1'b1;

    test_start = errors;
    repeat (300) put_char(sym_t'(rand_bits($bits(sym_t))));
    check_counts();
    report_test("counting");

    test_start = errors;
    run_scan();
    read_least(got);
    compare_least(got, model_least());
    report_test("scan");

    // one symbol only and then an empty table
    test_start = errors;
    clear_table();
    c = sym_t'(rand_bits($bits(sym_t)));
    repeat (5) put_char(c);
    run_scan();
    read_least(got);
    compare_least(got, model_least());
    clear_table();
    run_scan();
    read_least(got);
    compare_least(got, model_least());
    report_test("few symbols");

    // access phase opens two cycles after the clear starts
    test_start = errors;
    clear_table();
    c = sym_t'(rand_bits($bits(sym_t)));
    put_char(c);
    if (waits < `HUFF_ALPHA - 2) begin
      $display("char write finished after %0d wait states, before the clear ended", waits);
      errors++;
    end
    check_counts();
    report_test("clear backpressure");

    test_start = errors;
    apb_xfer(1'b1, OFF_STATUS, 32'h3);
    compare_flag("pslverr_o", slverr, 1'b1);
    apb_xfer(1'b0, OFF_CHAR, '0);
    compare_flag("pslverr_o", slverr, 1'b1);
    apb_xfer(1'b1, 10'h040, 32'h5);
    compare_flag("pslverr_o", slverr, 1'b1);
    check_counts();
    report_test("errors");

    test_start = errors;
    clear_table();
    c = sym_t'(rand_bits($bits(sym_t)));
    repeat (1 << `HUFF_CNT_W) put_char(c);
    apb_xfer(1'b0, addr_t'(OFF_COUNT + 4 * c), '0);
    compare_cnt("count", cnt_t'(rdata), '1);
    report_test("saturation");

    $display("tests 6, failed %0d, errors %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+src
src/huff_pkg.sv
src/huff_cmd_if.sv
src/huff_apb_decode.sv
src/huff_hist_table.sv
src/huff_least_scan.sv
src/huff_result.sv
src/huff_top.sv
verif/huff_tb.sv
